/* verilog/dcache_pkg.sv */
`default_nettype none

package dcache_pkg;

  // ------------------------------
  // geometry
  // ------------------------------
  localparam int unsigned xlen       = 32;
  localparam int unsigned line_bytes = 16;
  // words per line
  localparam int unsigned beats      = line_bytes / (xlen / 8);
  // beat counter and word offset width
  localparam int unsigned cnt_bits   = $clog2(beats);
  localparam int unsigned sets       = 16;
  localparam int unsigned off_bits   = $clog2(line_bytes);
  localparam int unsigned idx_bits   = $clog2(sets);
  localparam int unsigned tag_bits   = xlen - idx_bits - off_bits;
  // byte lane bits inside a word
  localparam int unsigned word_lsb   = $clog2(xlen / 8);

  // ------------------------------
  // data types
  // ------------------------------
  typedef logic [xlen-1:0]         word_t;
  typedef logic [8*line_bytes-1:0] line_t;
  typedef logic [xlen/8-1:0]       be_t;
  // byte enables over a whole line
  typedef logic [line_bytes-1:0]   lbe_t;

  typedef enum logic [1:0] {
    BYTE = 2'b00,
    HALF = 2'b01,
    WORD = 2'b10
  } size_e;

  // one cpu access
  typedef struct packed {
    logic [xlen-1:0] addr;
    logic            we;
    size_e           size;
    // store data already sits in its byte lanes
    word_t           wdata;
  } cpu_req_t;

  // one burst on the memory bus
  // write-back starts at word 0 of the line
  // a fill starts at the requested word and wraps
  typedef struct packed {
    logic [xlen-1:0] addr;
    logic            we;
  } bus_cmd_t;

  // byte enables from access size and low address bits
  function automatic be_t size2be(input size_e size, input logic [word_lsb-1:0] lsb);
    be_t be;
    case (size)
      BYTE:    be = be_t'(1) << lsb;
      HALF:    be = be_t'(3) << lsb;
      default: be = '1;
    endcase
    return be;
  endfunction

endpackage

`default_nettype wire

/* verilog/dcache_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module dcache_ctrl (
  input  wire                              clk_i,
  input  wire                              rst_ni,
  // cpu side
  input  wire                              req_valid_i,
  input  wire dcache_pkg::cpu_req_t        req_i,
  output logic                             ack_o,
  output dcache_pkg::word_t                rdata_o,
  // store read port
  input  wire [dcache_pkg::tag_bits-1:0]   rd_tag_i,
  input  wire                              rd_valid_i,
  input  wire                              rd_dirty_i,
  input  wire dcache_pkg::line_t           rd_line_i,
  // store write port
  output logic [dcache_pkg::idx_bits-1:0]  idx_o,
  output logic                             tag_we_o,
  output logic [dcache_pkg::tag_bits-1:0]  tag_o,
  output logic                             dirty_o,
  output logic                             line_we_o,
  output dcache_pkg::line_t                line_o,
  output dcache_pkg::lbe_t                 line_be_o,
  // burst engine
  input  wire                              done_i,
  input  wire dcache_pkg::line_t           fill_line_i,
  output logic                             start_o,
  output dcache_pkg::bus_cmd_t             cmd_o,
  output dcache_pkg::line_t                victim_o,
  output dcache_pkg::word_t                st_word_o,
  output dcache_pkg::be_t                  st_be_o
);

  typedef enum logic [1:0] {S_IDLE, S_LOOKUP, S_EVICT, S_FILL} state_e;

  state_e                          state_q;
  state_e                          state_d;
  dcache_pkg::cpu_req_t            req_q;
  logic                            ack_q;
  dcache_pkg::word_t               rdata_q;
  logic                            hit;
  logic                            victim_dirty;
  logic                            hit_write;
  logic                            fill_done;
  logic [dcache_pkg::cnt_bits-1:0] woff;
  logic [dcache_pkg::idx_bits-1:0] req_idx;
  dcache_pkg::be_t                 st_be;

  // ------------------------------
  // request decode
  // ------------------------------
  assign req_idx = req_q.addr[dcache_pkg::off_bits +: dcache_pkg::idx_bits];
  assign woff    = req_q.addr[dcache_pkg::off_bits-1:dcache_pkg::word_lsb];
  assign st_be   = dcache_pkg::size2be(req_q.size, req_q.addr[dcache_pkg::word_lsb-1:0]);

  // compare needs the store output, valid in lookup only
  assign hit          = rd_valid_i && (rd_tag_i == tag_o);
  assign victim_dirty = rd_valid_i && rd_dirty_i;
  assign hit_write    = (state_q == S_LOOKUP) && hit && req_q.we;
  assign fill_done    = (state_q == S_FILL) && done_i;

  // request payload
  always_ff @(posedge clk_i) begin
    if (req_valid_i) begin
      req_q <= req_i;
    end
  end

  // ------------------------------
  // access FSM
  // ------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      S_IDLE: begin
        if (req_valid_i) begin
          state_d = S_LOOKUP;
        end
      end
      S_LOOKUP: begin
        if (hit) begin
          state_d = S_IDLE;
        end else if (victim_dirty) begin
          state_d = S_EVICT;
        end else begin
          state_d = S_FILL;
        end
      end
      // write-back first, fill starts on its done
      S_EVICT: begin
        if (done_i) begin
          state_d = S_FILL;
        end
      end
      default: begin
        if (done_i) begin
          state_d = S_IDLE;
        end
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= S_IDLE;
      ack_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      ack_q   <= fill_done || ((state_q == S_LOOKUP) && hit);
    end
  end

  // load word, from the store on a hit or from the merged fill line
  always_ff @(posedge clk_i) begin
    if (fill_done) begin
      rdata_q <= fill_line_i[woff*dcache_pkg::xlen +: dcache_pkg::xlen];
    end else if (state_q == S_LOOKUP) begin
      rdata_q <= rd_line_i[woff*dcache_pkg::xlen +: dcache_pkg::xlen];
    end
  end

  assign ack_o   = ack_q;
  assign rdata_o = rdata_q;

  // ------------------------------
  // store port
  // ------------------------------
  // new index straight from the cpu so lookup sees the read a cycle later
  assign idx_o     = (state_q == S_IDLE) ?
                     req_i.addr[dcache_pkg::off_bits +: dcache_pkg::idx_bits] : req_idx;
  assign tag_o     = req_q.addr[dcache_pkg::xlen-1 -: dcache_pkg::tag_bits];
  // a store hit or a store miss leaves the line dirty
  assign dirty_o   = req_q.we;
  assign tag_we_o  = hit_write || fill_done;
  assign line_we_o = hit_write || fill_done;
  assign line_o    = fill_done ? fill_line_i : {dcache_pkg::beats{req_q.wdata}};
  assign line_be_o = fill_done ? '1 :
                     dcache_pkg::lbe_t'(st_be) << (woff * (dcache_pkg::xlen / 8));

  // ------------------------------
  // burst engine
  // ------------------------------
  assign start_o      = ((state_q == S_LOOKUP) && !hit) || ((state_q == S_EVICT) && done_i);
  assign cmd_o.we     = (state_q == S_LOOKUP) && victim_dirty;
  assign cmd_o.addr   = cmd_o.we ? {rd_tag_i, req_idx, {dcache_pkg::off_bits{1'b0}}} :
                        {req_q.addr[dcache_pkg::xlen-1:dcache_pkg::word_lsb],
                         {dcache_pkg::word_lsb{1'b0}}};
  assign victim_o     = rd_line_i;
  assign st_word_o    = req_q.wdata;
  assign st_be_o      = req_q.we ? st_be : '0;

  // cpu keeps one access in flight
  a_one_outstanding: assert property (
    @(posedge clk_i) disable iff (!rst_ni) req_valid_i |-> (state_q == S_IDLE)
  );

endmodule

`default_nettype wire

/* verilog/dcache_store.sv */
`timescale 1ns/100ps
`default_nettype none

module dcache_store (
  input  wire                              clk_i,
  input  wire                              rst_ni,
  input  wire [dcache_pkg::idx_bits-1:0]   idx_i,
  // tag write also sets valid
  input  wire                              tag_we_i,
  input  wire [dcache_pkg::tag_bits-1:0]   tag_i,
  input  wire                              dirty_i,
  // byte enabled line write
  input  wire                              line_we_i,
  input  wire dcache_pkg::line_t           line_i,
  input  wire dcache_pkg::lbe_t            line_be_i,
  // read data, one cycle after idx_i
  output logic [dcache_pkg::tag_bits-1:0]  rd_tag_o,
  output logic                             rd_valid_o,
  output logic                             rd_dirty_o,
  output dcache_pkg::line_t                rd_line_o
);

  logic [dcache_pkg::tag_bits-1:0] tag_mem   [dcache_pkg::sets];
  logic                            dirty_mem [dcache_pkg::sets];
  dcache_pkg::line_t               data_mem  [dcache_pkg::sets];
  logic [dcache_pkg::sets-1:0]     valid_q;

  // ------------------------------
  // valid bits
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q    <= '0;
      rd_valid_o <= 1'b0;
    end else begin
      rd_valid_o <= valid_q[idx_i];
      if (tag_we_i) begin
        valid_q[idx_i] <= 1'b1;
      end
    end
  end

  // ------------------------------
  // tag and dirty arrays
  // ------------------------------
  always_ff @(posedge clk_i) begin
    if (tag_we_i) begin
      tag_mem[idx_i]   <= tag_i;
      dirty_mem[idx_i] <= dirty_i;
    end
    // read returns the old contents on a same cycle write
    rd_tag_o   <= tag_mem[idx_i];
    rd_dirty_o <= dirty_mem[idx_i];
  end

  // ------------------------------
  // line data
  // ------------------------------
  always_ff @(posedge clk_i) begin
    if (line_we_i) begin
      for (int b = 0; b < dcache_pkg::line_bytes; b++) begin
        if (line_be_i[b]) begin
          data_mem[idx_i][8*b +: 8] <= line_i[8*b +: 8];
        end
      end
    end
    rd_line_o <= data_mem[idx_i];
  end

  // an empty line only gets data together with its tag
  a_fill_with_tag: assert property (
    @(posedge clk_i) disable iff (!rst_ni) line_we_i |-> (valid_q[idx_i] || tag_we_i)
  );

endmodule

`default_nettype wire

/* verilog/dcache_burst.sv */
`timescale 1ns/100ps
`default_nettype none

module dcache_burst (
  input  wire                              clk_i,
  input  wire                              rst_ni,
  // controller side
  input  wire                              start_i,
  input  wire dcache_pkg::bus_cmd_t        cmd_i,
  input  wire dcache_pkg::line_t           victim_i,
  input  wire dcache_pkg::word_t           st_word_i,
  input  wire dcache_pkg::be_t             st_be_i,
  output logic                             done_o,
  output dcache_pkg::line_t                fill_line_o,
  // memory bus
  input  wire                              bus_stb_ack_i,
  input  wire                              bus_ack_i,
  input  wire dcache_pkg::word_t           bus_rdata_i,
  input  wire [dcache_pkg::xlen-1:0]       bus_beat_addr_i,
  output logic                             bus_stb_o,
  output dcache_pkg::bus_cmd_t             bus_cmd_o,
  output dcache_pkg::word_t                bus_wdata_o
);

  typedef enum logic [1:0] {B_IDLE, B_STB, B_BURST} bstate_e;

  bstate_e                         state_q;
  logic [dcache_pkg::cnt_bits-1:0] cnt_q;
  logic                            done_q;
  dcache_pkg::bus_cmd_t            cmd_q;
  dcache_pkg::line_t               buf_q;
  logic [dcache_pkg::cnt_bits-1:0] boff;
  logic                            req_beat;
  logic                            last;
  dcache_pkg::word_t               beat;

  // word slot of the incoming beat
  assign boff     = bus_beat_addr_i[dcache_pkg::off_bits-1:dcache_pkg::word_lsb];
  // fills start at the requested word, so that beat takes the store data
  assign req_beat = bus_beat_addr_i[dcache_pkg::xlen-1:dcache_pkg::word_lsb] ==
                    cmd_q.addr[dcache_pkg::xlen-1:dcache_pkg::word_lsb];
  assign last     = (state_q == B_BURST) && bus_ack_i && (cnt_q == '0);

  // write-allocate merge
  always_comb begin
    beat = bus_rdata_i;
    for (int b = 0; b < dcache_pkg::xlen / 8; b++) begin
      if (req_beat && st_be_i[b]) begin
        beat[8*b +: 8] = st_word_i[8*b +: 8];
      end
    end
  end

  // ------------------------------
  // burst FSM
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= B_IDLE;
      cnt_q   <= '0;
      done_q  <= 1'b0;
    end else begin
      done_q <= last;
      case (state_q)
        B_IDLE: begin
          if (start_i) begin
            state_q <= B_STB;
            cnt_q   <= dcache_pkg::cnt_bits'(dcache_pkg::beats - 1);
          end
        end
        // strobe held until the memory takes the command
        B_STB: begin
          if (bus_stb_ack_i) begin
            state_q <= B_BURST;
          end
        end
        default: begin
          if (last) begin
            state_q <= B_IDLE;
          end else if (bus_ack_i) begin
            cnt_q <= cnt_q - 1'b1;
          end
        end
      endcase
    end
  end

  // command and line buffer
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      cmd_q <= cmd_i;
      if (cmd_i.we) begin
        buf_q <= victim_i;
      end
    end else if ((state_q == B_BURST) && bus_ack_i) begin
      if (cmd_q.we) begin
        // next victim word moves to the bottom
        buf_q <= buf_q >> dcache_pkg::xlen;
      end else begin
        buf_q[boff*dcache_pkg::xlen +: dcache_pkg::xlen] <= beat;
      end
    end
  end

  assign bus_stb_o   = (state_q == B_STB);
  assign bus_cmd_o   = cmd_q;
  assign bus_wdata_o = buf_q[dcache_pkg::xlen-1:0];
  // done comes after the last beat is in the buffer
  assign done_o      = done_q;
  assign fill_line_o = buf_q;

  // controller waits for done before the next burst
  a_start_idle: assert property (
    @(posedge clk_i) disable iff (!rst_ni) start_i |-> (state_q == B_IDLE)
  );

endmodule

`default_nettype wire

/* verilog/dcache_top.sv */
`timescale 1ns/100ps
`default_nettype none

module dcache_top (
  input  wire                         clk_i,
  input  wire                         rst_ni,
  // cpu load/store port
  input  wire                         req_valid_i,
  input  wire dcache_pkg::cpu_req_t   req_i,
  output logic                        ack_o,
  output dcache_pkg::word_t           rdata_o,
  // burst memory bus
  output logic                        bus_stb_o,
  output dcache_pkg::bus_cmd_t        bus_cmd_o,
  input  wire                         bus_stb_ack_i,
  input  wire                         bus_ack_i,
  input  wire dcache_pkg::word_t      bus_rdata_i,
  input  wire [dcache_pkg::xlen-1:0]  bus_beat_addr_i,
  output dcache_pkg::word_t           bus_wdata_o
);

  // ------------------------------
  // controller to store
  // ------------------------------
  logic [dcache_pkg::idx_bits-1:0] idx;
  logic                            tag_we;
  logic [dcache_pkg::tag_bits-1:0] tag;
  logic                            dirty;
  logic                            line_we;
  dcache_pkg::line_t               line;
  dcache_pkg::lbe_t                line_be;
  logic [dcache_pkg::tag_bits-1:0] rd_tag;
  logic                            rd_valid;
  logic                            rd_dirty;
  dcache_pkg::line_t               rd_line;

  // ------------------------------
  // controller to burst engine
  // ------------------------------
  logic                            start;
  dcache_pkg::bus_cmd_t            cmd;
  dcache_pkg::line_t               victim;
  dcache_pkg::word_t               st_word;
  dcache_pkg::be_t                 st_be;
  logic                            done;
  dcache_pkg::line_t               fill_line;

  dcache_ctrl u_ctrl (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_valid_i (req_valid_i),
    .req_i       (req_i),
    .ack_o       (ack_o),
    .rdata_o     (rdata_o),
    .rd_tag_i    (rd_tag),
    .rd_valid_i  (rd_valid),
    .rd_dirty_i  (rd_dirty),
    .rd_line_i   (rd_line),
    .idx_o       (idx),
    .tag_we_o    (tag_we),
    .tag_o       (tag),
    .dirty_o     (dirty),
    .line_we_o   (line_we),
    .line_o      (line),
    .line_be_o   (line_be),
    .done_i      (done),
    .fill_line_i (fill_line),
    .start_o     (start),
    .cmd_o       (cmd),
    .victim_o    (victim),
    .st_word_o   (st_word),
    .st_be_o     (st_be)
  );

  dcache_store u_store (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .idx_i      (idx),
    .tag_we_i   (tag_we),
    .tag_i      (tag),
    .dirty_i    (dirty),
    .line_we_i  (line_we),
    .line_i     (line),
    .line_be_i  (line_be),
    .rd_tag_o   (rd_tag),
    .rd_valid_o (rd_valid),
    .rd_dirty_o (rd_dirty),
    .rd_line_o  (rd_line)
  );

  dcache_burst u_burst (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .start_i         (start),
    .cmd_i           (cmd),
    .victim_i        (victim),
    .st_word_i       (st_word),
    .st_be_i         (st_be),
    .done_o          (done),
    .fill_line_o     (fill_line),
    .bus_stb_ack_i   (bus_stb_ack_i),
    .bus_ack_i       (bus_ack_i),
    .bus_rdata_i     (bus_rdata_i),
    .bus_beat_addr_i (bus_beat_addr_i),
    .bus_stb_o       (bus_stb_o),
    .bus_cmd_o       (bus_cmd_o),
    .bus_wdata_o     (bus_wdata_o)
  );

endmodule

`default_nettype wire

/* dv/bus_mem.sv */
`timescale 1ns/100ps
`default_nettype none

module bus_mem (
  input  wire                        clk_i,
  input  wire                        rst_ni,
  input  wire                        stb_i,
  input  wire dcache_pkg::bus_cmd_t  cmd_i,
  input  wire dcache_pkg::word_t     wdata_i,
  output logic                       stb_ack_o,
  output logic                       ack_o,
  output dcache_pkg::word_t          rdata_o,
  output logic [31:0]                beat_addr_o
);

  // 4 KB of words, also peeked by the testbench
  dcache_pkg::word_t    mem [1024];
  dcache_pkg::bus_cmd_t cmd_q;
  dcache_pkg::bus_cmd_t cmd_s;
  logic                 stb_s;
  logic                 busy;
  logic                 stalled;
  logic [1:0]           word;
  int                   left;
  int                   count;

  initial begin
    // each word starts as its own address xor a marker
    for (int i = 0; i < 1024; i++) begin
      mem[i] = 32'(i * 4) ^ 32'h5A5A0000;
    end
    stb_ack_o   = 1'b0;
    ack_o       = 1'b0;
    rdata_o     = '0;
    beat_addr_o = '0;
    cmd_q       = '0;
    busy        = 1'b0;
    stalled     = 1'b0;
    left        = 0;
    count       = 0;
    forever begin
      // ------------------------------
      // mid-cycle sample
      // ------------------------------
      @(negedge clk_i);
      // beat in flight completes at the next rising edge
      if (ack_o) begin
        if (cmd_q.we) begin
          mem[beat_addr_o[11:2]] = wdata_i;
        end
        left--;
        count++;
      end
      stb_s = stb_i && !stb_ack_o && !busy;
      cmd_s = cmd_i;
      // ------------------------------
      // drive just after the edge
      // ------------------------------
      @(posedge clk_i);
      #1;
      stb_ack_o = 1'b0;
      ack_o     = 1'b0;
      if (!rst_ni) begin
        busy    = 1'b0;
        stalled = 1'b0;
        left    = 0;
      end else if (stb_s) begin
        stb_ack_o = 1'b1;
        cmd_q     = cmd_s;
        busy      = 1'b1;
        left      = dcache_pkg::beats;
      end else if (busy && left == 0) begin
        busy = 1'b0;
      end else if (busy && (count % 3 == 2) && !stalled) begin
        // one idle cycle before every third beat
        stalled = 1'b1;
      end else if (busy) begin
        stalled     = 1'b0;
        ack_o       = 1'b1;
        // wrap order from the requested word
        word        = cmd_q.addr[3:2] + 2'(dcache_pkg::beats - left);
        beat_addr_o = {cmd_q.addr[31:4], word, 2'b00};
        rdata_o     = mem[beat_addr_o[11:2]];
      end
    end
  end

endmodule

`default_nettype wire

/* dv/tb_dcache.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_dcache;

  typedef enum logic [1:0] {OP_LD, OP_ST, OP_MEM} op_e;

  // one row of the directed table
  typedef struct packed {
    op_e                 op;
    logic                hit;
    logic [31:0]         addr;
    dcache_pkg::size_e   size;
    dcache_pkg::word_t   data;
    dcache_pkg::word_t   exp;
  } entry_t;

  logic                 clk = 1'b0;
  logic                 rst_n;
  logic                 req_valid;
  dcache_pkg::cpu_req_t req;
  logic                 ack;
  dcache_pkg::word_t    rdata;
  logic                 bus_stb;
  dcache_pkg::bus_cmd_t bus_cmd;
  logic                 bus_stb_ack;
  logic                 bus_ack;
  dcache_pkg::word_t    bus_rdata;
  logic [31:0]          bus_beat_addr;
  dcache_pkg::word_t    bus_wdata;

  int                   errors = 0;
  int                   checks = 0;
  logic                 hung = 1'b0;
  entry_t               stim[$];
  // byte image of what memory plus cache should hold
  logic [7:0]           ref_mem [4096];
  entry_t               e;
  dcache_pkg::word_t    rd;
  int                   lat;
  logic                 saw;
  // last command strobed during the access
  dcache_pkg::bus_cmd_t last_cmd;
  logic [31:0]          rnd = 32'd10;
  logic [31:0]          addr;
  logic                 we;
  dcache_pkg::size_e    size;
  dcache_pkg::word_t    w;

  dcache_top dut (
    .clk_i           (clk),
    .rst_ni          (rst_n),
    .req_valid_i     (req_valid),
    .req_i           (req),
    .ack_o           (ack),
    .rdata_o         (rdata),
    .bus_stb_o       (bus_stb),
    .bus_cmd_o       (bus_cmd),
    .bus_stb_ack_i   (bus_stb_ack),
    .bus_ack_i       (bus_ack),
    .bus_rdata_i     (bus_rdata),
    .bus_beat_addr_i (bus_beat_addr),
    .bus_wdata_o     (bus_wdata)
  );

  bus_mem u_mem (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .stb_i       (bus_stb),
    .cmd_i       (bus_cmd),
    .wdata_i     (bus_wdata),
    .stb_ack_o   (bus_stb_ack),
    .ack_o       (bus_ack),
    .rdata_o     (bus_rdata),
    .beat_addr_o (bus_beat_addr)
  );

  always #50 clk = ~clk;

  // ------------------------------
  // helpers
  // ------------------------------
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic add_entry(input op_e op, input logic hit, input logic [31:0] a,
                           input dcache_pkg::size_e sz, input logic [31:0] d,
                           input logic [31:0] x);
    entry_t n;
    n.op   = op;
    n.hit  = hit;
    n.addr = a;
    n.size = sz;
    n.data = d;
    n.exp  = x;
    stim.push_back(n);
  endtask

  function automatic logic [31:0] predict_word(input logic [31:0] a);
    int b;
    b = {a[11:2], 2'b00};
    return {ref_mem[b+3], ref_mem[b+2], ref_mem[b+1], ref_mem[b]};
  endfunction

  // store data sits in its byte lanes already
  task automatic record_store(input logic [31:0] a, input dcache_pkg::size_e sz,
                              input logic [31:0] d);
    int n;
    n = (sz == dcache_pkg::BYTE) ? 1 : ((sz == dcache_pkg::HALF) ? 2 : 4);
    for (int i = 0; i < n; i++) begin
      ref_mem[int'(a[11:0]) + i] = d[8*(int'(a[1:0]) + i) +: 8];
    end
  endtask

  // one strobe then wait at most 200 cycles for ack
  task automatic run_access(input logic wr, input logic [31:0] a,
                            input dcache_pkg::size_e sz, input logic [31:0] d);
    req.addr  = a;
    req.we    = wr;
    req.size  = sz;
    req.wdata = d;
    req_valid = 1'b1;
    @(posedge clk);
    #1;
    req_valid = 1'b0;
    lat = 1;
    saw = bus_stb;
    last_cmd = '0;
    if (bus_stb) begin
      last_cmd = bus_cmd;
    end
    while (!ack && lat < 200) begin
      @(posedge clk);
      #1;
      lat++;
      saw = saw | bus_stb;
      if (bus_stb) begin
        last_cmd = bus_cmd;
      end
    end
    if (!ack) begin
      errors++;
      hung = 1'b1;
      $display("no ack from the cache within 200 cycles for address %h", a);
    end
    rd = rdata;
  endtask

  task automatic finish_run();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  endtask

  // ------------------------------
  // watchdog
  // ------------------------------
  initial begin
    wait (rst_n);
    repeat ((stim.size() + 40) * 40) @(posedge clk);
    errors++;
    $display("watchdog expired, the run did not complete in time");
    finish_run();
  end

  // ------------------------------
  // main sequence
  // ------------------------------
  initial begin
    rst_n     = 1'b0;
    req_valid = 1'b0;
    req       = '0;
    for (int a = 0; a < 4096; a++) begin
      w          = 32'(a & ~3) ^ 32'h5A5A0000;
      ref_mem[a] = w[8*(a%4) +: 8];
    end
    // load miss then hits on the same line
    add_entry(OP_LD, 1'b0, 32'h040, dcache_pkg::WORD, 32'h0, 32'h5A5A0040);
    add_entry(OP_LD, 1'b1, 32'h040, dcache_pkg::WORD, 32'h0, 32'h5A5A0040);
    add_entry(OP_LD, 1'b1, 32'h044, dcache_pkg::WORD, 32'h0, 32'h5A5A0044);
    // partial store hits
    add_entry(OP_ST, 1'b1, 32'h041, dcache_pkg::BYTE, 32'h0000AB00, 32'h0);
    add_entry(OP_LD, 1'b1, 32'h040, dcache_pkg::WORD, 32'h0, 32'h5A5AAB40);
    add_entry(OP_ST, 1'b1, 32'h046, dcache_pkg::HALF, 32'hCDEF0000, 32'h0);
    add_entry(OP_LD, 1'b1, 32'h044, dcache_pkg::WORD, 32'h0, 32'hCDEF0044);
    add_entry(OP_ST, 1'b1, 32'h043, dcache_pkg::BYTE, 32'h77000000, 32'h0);
    add_entry(OP_LD, 1'b1, 32'h040, dcache_pkg::WORD, 32'h0, 32'h775AAB40);
    // write-allocate
    add_entry(OP_ST, 1'b0, 32'h088, dcache_pkg::WORD, 32'h12345678, 32'h0);
    add_entry(OP_LD, 1'b1, 32'h088, dcache_pkg::WORD, 32'h0, 32'h12345678);
    add_entry(OP_ST, 1'b0, 32'h0C2, dcache_pkg::HALF, 32'hBEEF0000, 32'h0);
    add_entry(OP_LD, 1'b1, 32'h0C0, dcache_pkg::WORD, 32'h0, 32'hBEEF00C0);
    add_entry(OP_LD, 1'b1, 32'h0C4, dcache_pkg::WORD, 32'h0, 32'h5A5A00C4);
    // set 0 conflict where the dirty victim goes back to memory
    add_entry(OP_ST, 1'b0, 32'h104, dcache_pkg::WORD, 32'hA5A5A5A5, 32'h0);
    add_entry(OP_LD, 1'b0, 32'h204, dcache_pkg::WORD, 32'h0, 32'h5A5A0204);
    add_entry(OP_MEM, 1'b0, 32'h104, dcache_pkg::WORD, 32'h0, 32'hA5A5A5A5);
    add_entry(OP_MEM, 1'b0, 32'h100, dcache_pkg::WORD, 32'h0, 32'h5A5A0100);
    add_entry(OP_LD, 1'b0, 32'h104, dcache_pkg::WORD, 32'h0, 32'hA5A5A5A5);
    // set 4 conflict
    add_entry(OP_LD, 1'b0, 32'h340, dcache_pkg::WORD, 32'h0, 32'h5A5A0340);
    add_entry(OP_MEM, 1'b0, 32'h040, dcache_pkg::WORD, 32'h0, 32'h775AAB40);
    add_entry(OP_MEM, 1'b0, 32'h044, dcache_pkg::WORD, 32'h0, 32'hCDEF0044);
    add_entry(OP_LD, 1'b0, 32'h044, dcache_pkg::WORD, 32'h0, 32'hCDEF0044);

    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;
    // quiet bus and cpu port after reset
    repeat (3) begin
      @(posedge clk);
      #1;
      check("ack_o", 32'(ack), 32'h0);
      check("bus_stb_o", 32'(bus_stb), 32'h0);
    end

    foreach (stim[i]) begin
      e = stim[i];
      if (hung) begin
        continue;
      end
      if (e.op == OP_MEM) begin
        check("bus_mem word", u_mem.mem[e.addr[11:2]], e.exp);
      end else begin
        run_access(e.op == OP_ST, e.addr, e.size, e.data);
        if (e.op == OP_ST) begin
          record_store(e.addr, e.size, e.data);
        end else begin
          check("rdata_o", rd, e.exp);
        end
        // hits answer in 2 cycles and leave the bus alone
        if (e.hit) begin
          check("ack latency", lat, 32'd2);
          check("bus_stb_o", 32'(saw), 32'h0);
        end else begin
          check("bus_stb_o", 32'(saw), 32'h1);
          // a miss ends with the fill that starts at the requested word
          check("bus_cmd_o.addr", last_cmd.addr, {e.addr[31:2], 2'b00});
          check("bus_cmd_o.we", 32'(last_cmd.we), 32'h0);
        end
      end
    end

    // ------------------------------
    // random sweep over 4 KB
    // ------------------------------
    for (int i = 0; i < 40; i++) begin
      if (hung) begin
        break;
      end
      rnd  = xorshift32(rnd);
      addr = {20'h0, rnd[11:0]};
      we   = rnd[12];
      case (rnd[14:13])
        2'd0:    size = dcache_pkg::BYTE;
        2'd1:    size = dcache_pkg::HALF;
        default: size = dcache_pkg::WORD;
      endcase
      // loads read whole words
      if (!we) begin
        size = dcache_pkg::WORD;
      end
      if (size == dcache_pkg::HALF) begin
        addr[0] = 1'b0;
      end else if (size == dcache_pkg::WORD) begin
        addr[1:0] = 2'b00;
      end
      rnd = xorshift32(rnd);
      run_access(we, addr, size, rnd);
      if (we) begin
        record_store(addr, size, rnd);
      end else begin
        check("rdata_o", rd, predict_word(addr));
      end
    end

    finish_run();
  end

endmodule

`default_nettype wire

/* list.f */
verilog/dcache_pkg.sv
verilog/dcache_ctrl.sv
verilog/dcache_store.sv
verilog/dcache_burst.sv
verilog/dcache_top.sv
dv/bus_mem.sv
dv/tb_dcache.sv

/* Makefile */
TOP := tb_dcache

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f list.f \
		--top-module $(TOP) -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf obj_dir
